/* common/e100_config.svh */
////////////////////////////////////////
// E100 build-time sizes
// word width, address width and
// number of words in the memory
////////////////////////////////////////

`ifndef E100_CONFIG_SVH
`define E100_CONFIG_SVH

// data word
`define E100_WORD_WIDTH 32

// memory addressing, 1024 words
`define E100_ADDR_WIDTH 10
`define E100_MEM_DEPTH  1024

`endif

/* common/e100_pkg.sv */
////////////////////////////////////////
// E100 shared types
//  word and address types
//  opcode encodings
//  four-word instruction struct
//  fetch and execute state encodings
////////////////////////////////////////

`include "e100_config.svh"

package e100_pkg;

    typedef logic [`E100_WORD_WIDTH-1:0] word_t;

    // low bits of a word select a memory location
    typedef logic [`E100_ADDR_WIDTH-1:0] addr_t;

    // reference encodings; 3, 4, 11, 12, 16, 17 are not supported
    typedef enum logic [`E100_WORD_WIDTH-1:0] {
        op_halt = 0,
        op_add  = 1,
        op_sub  = 2,
        op_cp   = 5,
        op_and  = 6,
        op_or   = 7,
        op_not  = 8,
        op_sl   = 9,
        op_sr   = 10,
        op_be   = 13,
        op_bne  = 14,
        op_blt  = 15
    } opcode_t;

    // opcode word kept raw so unknown codes survive the fetch
    typedef struct packed {
        word_t opcode;
        word_t arg1;
        word_t arg2;
        word_t arg3;
    } instr_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_read,
        fetch_wait_last,
        fetch_issue
    } fetch_state_t;

    typedef enum logic [2:0] {
        exec_idle,
        exec_read_a,
        exec_read_b,
        exec_compute,
        exec_write,
        exec_halted
    } exec_state_t;

endpackage

/* common/e100_mem_if.sv */
////////////////////////////////////////
// requester to memory port
// single-cycle request strobe, read
// data one cycle later
////////////////////////////////////////

`timescale 1ns/1ns

interface e100_mem_if;
    import e100_pkg::*;

    logic  request;
    addr_t address;
    logic  write;
    word_t write_data;
    word_t read_data;

    modport requester (
        output request, address, write, write_data,
        input  read_data
    );

    modport memory (
        input  request, address, write, write_data,
        output read_data
    );

endinterface

/* verilog/e100_memory.sv */
////////////////////////////////////////
// E100 word memory
//  two requester ports, registered reads
//  program load port and peek port
////////////////////////////////////////

`timescale 1ns/1ns
`include "e100_config.svh"

module e100_memory (
    input  logic            clock,
    input  logic            reset,
    input  logic            load,
    input  e100_pkg::addr_t load_address,
    input  e100_pkg::word_t load_data,
    input  e100_pkg::addr_t peek_address,
    e100_mem_if.memory      fetch_mem,
    e100_mem_if.memory      exec_mem,
    output e100_pkg::word_t peek_data
);
    import e100_pkg::*;

    word_t words [`E100_MEM_DEPTH];

    // at most one writer per cycle, load only happens in reset
    always_ff @(posedge clock) begin
        if (load) begin
            words[load_address] <= load_data;
        end else if (exec_mem.request && exec_mem.write) begin
            words[exec_mem.address] <= exec_mem.write_data;
        end else if (fetch_mem.request && fetch_mem.write) begin
            words[fetch_mem.address] <= fetch_mem.write_data;
        end
    end

    // read data held until the next read of that port
    always_ff @(posedge clock) begin
        if (fetch_mem.request && !fetch_mem.write) begin
            fetch_mem.read_data <= words[fetch_mem.address];
        end
        if (exec_mem.request && !exec_mem.write) begin
            exec_mem.read_data <= words[exec_mem.address];
        end
    end

    assign peek_data = words[peek_address];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // fetch and execute take turns, never overlap
    a_one_requester: assert property (@(posedge clock) disable iff (reset)
        !(fetch_mem.request && exec_mem.request));

    a_load_in_reset: assert property (@(posedge clock) load |-> reset);

endmodule

/* e100_core/e100_fetch.sv */
////////////////////////////////////////
// E100 fetch unit
//  instruction address register
//  four-word fetch sequence
//  instr_valid strobe to execute
////////////////////////////////////////

`timescale 1ns/1ns

module e100_fetch (
    input  logic             clock,
    input  logic             reset,
    input  logic             done,
    input  logic             branch_taken,
    input  e100_pkg::addr_t  branch_target,
    e100_mem_if.requester    mem,
    output logic             instr_valid,
    output e100_pkg::instr_t instr
);
    import e100_pkg::*;

    fetch_state_t state;
    addr_t        iar;
    logic [1:0]   word_count;
    logic         kick;
    instr_t       instr_q;

    // high through reset and in the first cycle after it
    always_ff @(posedge clock) begin
        kick <= reset;
    end

    ////////////////////////////////////////
    // sequence control
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= fetch_idle;
            word_count <= '0;
            iar        <= '0;
        end else begin
            case (state)
                fetch_idle: begin
                    if (kick || done) begin
                        state <= fetch_read;
                    end
                end
                fetch_read: begin
                    // count wraps back to 0 after the arg3 read
                    word_count <= word_count + 2'd1;
                    if (word_count == 2'd3) begin
                        state <= fetch_wait_last;
                    end
                end
                fetch_wait_last: begin
                    state <= fetch_issue;
                end
                fetch_issue: begin
                    state <= fetch_idle;
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase

            // next instruction address, in place before the reads start
            if (done) begin
                iar <= branch_taken ? branch_target : iar + addr_t'(4);
            end
        end
    end

    ////////////////////////////////////////
    // word capture
    ////////////////////////////////////////

    // each word lands one cycle after its read
    always_ff @(posedge clock) begin
        if (state == fetch_read && word_count != 2'd0) begin
            case (word_count)
                2'd1:    instr_q.opcode <= mem.read_data;
                2'd2:    instr_q.arg1   <= mem.read_data;
                default: instr_q.arg2   <= mem.read_data;
            endcase
        end else if (state == fetch_wait_last) begin
            instr_q.arg3 <= mem.read_data;
        end
    end

    assign mem.request    = (state == fetch_read);
    assign mem.address    = iar + addr_t'(word_count);
    assign mem.write      = 1'b0;
    assign mem.write_data = '0;

    assign instr_valid = (state == fetch_issue);
    assign instr       = instr_q;

    // execute finishes only while fetch is waiting on it
    a_done_when_idle: assert property (@(posedge clock) disable iff (reset)
        done |-> state == fetch_idle);

endmodule

/* e100_core/e100_execute.sv */
////////////////////////////////////////
// E100 execute unit
//  opcode decode and execute FSM
//  operand registers and result logic
//  branch decision and halt
////////////////////////////////////////

`timescale 1ns/1ns

module e100_execute (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    input  e100_pkg::instr_t instr,
    e100_mem_if.requester    mem,
    output logic             done,
    output logic             branch_taken,
    output e100_pkg::addr_t  branch_target,
    output logic             halted
);
    import e100_pkg::*;

    exec_state_t state;
    instr_t      instr_q;
    word_t       op1;
    word_t       op2;
    opcode_t     op;
    opcode_t     new_op;
    word_t       result;
    logic        take;

    ////////////////////////////////////////
    // opcode classes
    ////////////////////////////////////////

    // needs mem[arg3] as a second operand
    function automatic logic uses_op2(opcode_t code);
        case (code)
            op_add, op_sub, op_and, op_or, op_sl, op_sr: return 1'b1;
            op_be, op_bne, op_blt:                       return 1'b1;
            default:                                     return 1'b0;
        endcase
    endfunction

    // result goes back to mem[arg1]
    function automatic logic writes_mem(opcode_t code);
        case (code)
            op_add, op_sub, op_cp, op_and, op_or: return 1'b1;
            op_not, op_sl, op_sr:                 return 1'b1;
            default:                              return 1'b0;
        endcase
    endfunction

    function automatic logic is_branch(opcode_t code);
        return (code == op_be) || (code == op_bne) || (code == op_blt);
    endfunction

    assign op     = opcode_t'(instr_q.opcode);
    assign new_op = opcode_t'(instr.opcode);

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= exec_idle;
        end else begin
            case (state)
                exec_idle: begin
                    if (instr_valid) begin
                        if (new_op == op_halt) begin
                            state <= exec_halted;
                        end else if (writes_mem(new_op) || is_branch(new_op)) begin
                            state <= exec_read_a;
                        end else begin
                            // unknown opcode, straight to done as a no-op
                            state <= exec_write;
                        end
                    end
                end
                exec_read_a: begin
                    state <= exec_read_b;
                end
                exec_read_b: begin
                    state <= uses_op2(op) ? exec_compute : exec_write;
                end
                exec_compute: begin
                    state <= exec_write;
                end
                exec_write: begin
                    state <= exec_idle;
                end
                exec_halted: begin
                    state <= exec_halted;
                end
                default: begin
                    state <= exec_idle;
                end
            endcase
        end
    end

    // instruction and operands, loaded as the read data comes back
    always_ff @(posedge clock) begin
        if (state == exec_idle && instr_valid) begin
            instr_q <= instr;
        end
        if (state == exec_read_b) begin
            op1 <= mem.read_data;
        end
        if (state == exec_compute) begin
            op2 <= mem.read_data;
        end
    end

    ////////////////////////////////////////
    // result and branch decision
    ////////////////////////////////////////

    always_comb begin
        case (op)
            op_add:  result = op1 + op2;
            op_sub:  result = op1 - op2;
            op_and:  result = op1 & op2;
            op_or:   result = op1 | op2;
            op_not:  result = ~op1;
            // shift counts of 32 or more give zero
            op_sl:   result = op1 << op2;
            op_sr:   result = op1 >> op2;
            default: result = op1;
        endcase

        // blt is an unsigned compare
        case (op)
            op_be:   take = (op1 == op2);
            op_bne:  take = (op1 != op2);
            op_blt:  take = (op1 < op2);
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        case (state)
            exec_read_a: mem.address = addr_t'(instr_q.arg2);
            exec_read_b: mem.address = addr_t'(instr_q.arg3);
            default:     mem.address = addr_t'(instr_q.arg1);
        endcase
    end

    assign mem.request = (state == exec_read_a) ||
                         (state == exec_read_b && uses_op2(op)) ||
                         (state == exec_write && writes_mem(op));
    assign mem.write      = (state == exec_write);
    assign mem.write_data = result;

    assign done          = (state == exec_write);
    assign branch_taken  = done && is_branch(op) && take;
    assign branch_target = addr_t'(instr_q.arg1);
    assign halted        = (state == exec_halted);

    // fetch hands over a new instruction only once the last one is done
    a_valid_when_idle: assert property (@(posedge clock) disable iff (reset)
        instr_valid |-> state == exec_idle);

endmodule

/* verilog/e100_top.sv */
////////////////////////////////////////
// E100 processor top level
//  fetch, execute and word memory
//  program load and result peek ports
////////////////////////////////////////

`timescale 1ns/1ns

module e100_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            load,
    input  e100_pkg::addr_t load_address,
    input  e100_pkg::word_t load_data,
    input  e100_pkg::addr_t peek_address,
    output e100_pkg::word_t peek_data,
    output logic            halted
);
    import e100_pkg::*;

    // fetch to execute handover
    logic   instr_valid;
    instr_t instr;

    // execute back to fetch
    logic   done;
    logic   branch_taken;
    addr_t  branch_target;

    e100_mem_if fetch_mem ();
    e100_mem_if exec_mem ();

    e100_fetch i_e100_fetch (
        .clock         (clock),
        .reset         (reset),
        .done          (done),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem           (fetch_mem.requester),
        .instr_valid   (instr_valid),
        .instr         (instr)
    );

    e100_execute i_e100_execute (
        .clock         (clock),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .mem           (exec_mem.requester),
        .done          (done),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halted        (halted)
    );

    e100_memory i_e100_memory (
        .clock        (clock),
        .reset        (reset),
        .load         (load),
        .load_address (load_address),
        .load_data    (load_data),
        .peek_address (peek_address),
        .fetch_mem    (fetch_mem.memory),
        .exec_mem     (exec_mem.memory),
        .peek_data    (peek_data)
    );

endmodule

/* sim/e100_tb.sv */
////////////////////////////////////////
// E100 testbench
//  reference interpreter and LCG
//  program loader and peek checks
//  directed ALU and branch programs
//  random programs
////////////////////////////////////////

`timescale 1ns/1ns
`include "e100_config.svh"

module e100_tb;
    import e100_pkg::*;

    localparam int depth      = `E100_MEM_DEPTH;
    localparam int data_base  = 512;
    localparam int max_steps  = 1000;
    localparam int rand_count = 40;

    // reference encodings
    localparam word_t code_halt = 32'd0;
    localparam word_t code_add  = 32'd1;
    localparam word_t code_sub  = 32'd2;
    localparam word_t code_cp   = 32'd5;
    localparam word_t code_and  = 32'd6;
    localparam word_t code_or   = 32'd7;
    localparam word_t code_not  = 32'd8;
    localparam word_t code_sl   = 32'd9;
    localparam word_t code_sr   = 32'd10;
    localparam word_t code_be   = 32'd13;
    localparam word_t code_bne  = 32'd14;
    localparam word_t code_blt  = 32'd15;

    // random opcode mix, 3 and 11 are unknown codes
    localparam word_t opcode_table [16] = '{
        32'd1, 32'd2, 32'd5, 32'd6, 32'd7, 32'd8, 32'd9, 32'd10,
        32'd13, 32'd14, 32'd15, 32'd13, 32'd14, 32'd15, 32'd3, 32'd11
    };

    logic  clock;
    logic  reset;
    logic  load;
    addr_t load_address;
    word_t load_data;
    addr_t peek_address;
    word_t peek_data;
    logic  halted;

    word_t image  [depth];
    word_t shadow [depth];
    word_t marker_expect [16];
    word_t lcg_state;
    int    cycle_count;
    int    cycle_limit;
    int    steps;

    e100_top i_e100_top (
        .clock        (clock),
        .reset        (reset),
        .load         (load),
        .load_address (load_address),
        .load_data    (load_data),
        .peek_address (peek_address),
        .peek_data    (peek_data),
        .halted       (halted)
    );

    always #5 clock = ~clock;

    task automatic fail_run(string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // cycles spent running, bounded per program
    always @(posedge clock) begin
        if (reset || halted) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                fail_run($sformatf("timeout: no halt after %0d cycles", cycle_count));
            end
        end
    end

    a_halted_holds: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else fail_run("halted dropped while reset was low");

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////////////////////////
    // reference interpreter
    ////////////////////////////////////////

    // runs the shadow image to halt, returns instructions executed
    function automatic int interpret();
        addr_t pc;
        addr_t next_pc;
        word_t opc;
        word_t a1;
        word_t a2;
        word_t a3;
        word_t x;
        word_t y;
        int    count;
        logic  stop;
        pc    = '0;
        count = 0;
        stop  = 1'b0;
        while (!stop && count < max_steps) begin
            opc     = shadow[pc];
            a1      = shadow[pc + addr_t'(1)];
            a2      = shadow[pc + addr_t'(2)];
            a3      = shadow[pc + addr_t'(3)];
            x       = shadow[addr_t'(a2)];
            y       = shadow[addr_t'(a3)];
            next_pc = pc + addr_t'(4);
            count++;
            case (opc)
                code_halt: stop = 1'b1;
                code_add:  shadow[addr_t'(a1)] = x + y;
                code_sub:  shadow[addr_t'(a1)] = x - y;
                code_cp:   shadow[addr_t'(a1)] = x;
                code_and:  shadow[addr_t'(a1)] = x & y;
                code_or:   shadow[addr_t'(a1)] = x | y;
                code_not:  shadow[addr_t'(a1)] = ~x;
                code_sl:   shadow[addr_t'(a1)] = (y >= 32) ? 32'd0 : (x << y);
                code_sr:   shadow[addr_t'(a1)] = (y >= 32) ? 32'd0 : (x >> y);
                code_be:   if (x == y) next_pc = addr_t'(a1);
                code_bne:  if (x != y) next_pc = addr_t'(a1);
                code_blt:  if (x < y) next_pc = addr_t'(a1);
                default:   ;
            endcase
            pc = next_pc;
        end
        return count;
    endfunction

    ////////////////////////////////////////
    // program building
    ////////////////////////////////////////

    task automatic put_instr(int index, word_t code, int a1, int a2, int a3);
        image[addr_t'(4 * index)]     = code;
        image[addr_t'(4 * index + 1)] = word_t'(a1);
        image[addr_t'(4 * index + 2)] = word_t'(a2);
        image[addr_t'(4 * index + 3)] = word_t'(a3);
    endtask

    task automatic fill_image();
        for (int i = 0; i < depth; i++) begin
            image[addr_t'(i)] = {addr_t'(i), ~addr_t'(i), 12'h3c5};
        end
        // operand area
        for (int i = data_base; i < data_base + 64; i++) begin
            image[addr_t'(i)] = next_random();
        end
    endtask

    function automatic int data_slot();
        word_t r;
        r = next_random();
        return data_base + int'(r[21:16]);
    endfunction

    // branch over a marker copy, target is the instruction after it
    task automatic branch_case(int k, word_t code, int xa, int ya, logic taken);
        put_instr(2 * k, code, 4 * (2 * k + 2), xa, ya);
        put_instr(2 * k + 1, code_cp, 540 + k, 520, 0);
        marker_expect[k[3:0]] = taken ? image[addr_t'(540 + k)] : image[addr_t'(520)];
    endtask

    task automatic build_alu_program();
        fill_image();
        image[addr_t'(515)] = 32'd5;
        image[addr_t'(516)] = 32'd32;
        image[addr_t'(517)] = 32'd31;
        image[addr_t'(518)] = 32'd40;
        put_instr(0, code_add, 540, 512, 513);
        put_instr(1, code_sub, 541, 512, 513);
        put_instr(2, code_and, 542, 512, 513);
        put_instr(3, code_or, 543, 512, 513);
        put_instr(4, code_not, 544, 512, 0);
        put_instr(5, code_sl, 545, 512, 515);
        put_instr(6, code_sl, 546, 512, 516);
        put_instr(7, code_sr, 547, 513, 517);
        put_instr(8, code_sr, 548, 513, 518);
        put_instr(9, code_cp, 549, 514, 0);
        put_instr(10, 32'd3, 550, 512, 513);
        put_instr(11, code_sub, 551, 513, 512);
        put_instr(12, 32'd20, 550, 514, 514);
        put_instr(13, code_halt, 0, 0, 0);
    endtask

    task automatic build_branch_program();
        fill_image();
        image[addr_t'(530)] = 32'd7;
        image[addr_t'(531)] = 32'd7;
        image[addr_t'(532)] = 32'd9;
        image[addr_t'(533)] = 32'd1;
        image[addr_t'(534)] = 32'h8000_0000;
        branch_case(0, code_be, 530, 531, 1'b1);
        branch_case(1, code_be, 530, 532, 1'b0);
        branch_case(2, code_bne, 530, 532, 1'b1);
        branch_case(3, code_bne, 530, 531, 1'b0);
        // unsigned compare, taken although negative when signed
        branch_case(4, code_blt, 533, 534, 1'b1);
        branch_case(5, code_blt, 534, 533, 1'b0);
        branch_case(6, code_blt, 530, 531, 1'b0);
        put_instr(14, code_halt, 0, 0, 0);
    endtask

    // forward branches only, so every program reaches its halt
    task automatic build_random_program();
        word_t r;
        word_t code;
        int    target;
        fill_image();
        for (int i = 0; i < 8; i++) begin
            image[addr_t'(data_base + i)] = next_random() % 32'd40;
        end
        for (int i = 0; i < rand_count - 1; i++) begin
            r    = next_random();
            code = opcode_table[r[19:16]];
            if (code == code_be || code == code_bne || code == code_blt) begin
                target = i + 1 + int'(r[31:24]) % (rand_count - 1 - i);
                put_instr(i, code, 4 * target, data_slot(), data_slot());
            end else begin
                put_instr(i, code, data_slot(), data_slot(), data_slot());
            end
        end
        put_instr(rand_count - 1, code_halt, 0, 0, 0);
    endtask

    ////////////////////////////////////////
    // running and checking
    ////////////////////////////////////////

    // called on a falling edge, returns one falling edge later
    task automatic check_word(int where, word_t expected, string what);
        peek_address = addr_t'(where);
        @(negedge clock);
        assert (peek_data === expected)
            else fail_run($sformatf("mismatch at %0t ns: %s, mem[%0d] is %h, expected %h",
                $time, what, where, peek_data, expected));
    endtask

    task automatic run_image(string name);
        shadow      = image;
        steps       = interpret();
        cycle_limit = steps * 12 + 100;
        for (int i = 0; i < depth; i++) begin
            @(negedge clock);
            reset        = 1'b1;
            load         = 1'b1;
            load_address = addr_t'(i);
            load_data    = image[addr_t'(i)];
        end
        @(negedge clock);
        load = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (!halted) else fail_run("halted is high right after reset");
        while (!halted) begin
            @(negedge clock);
        end
        $display("%s: %0d instructions, halted", name, steps);
        // nothing may change once halted
        for (int c = 0; c < 50; c++) begin
            check_word(data_base + c, shadow[addr_t'(data_base + c)], "write after halt");
        end
        for (int i = 0; i < depth; i++) begin
            check_word(i, shadow[addr_t'(i)], "final memory image");
        end
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        load         = 1'b0;
        load_address = '0;
        load_data    = '0;
        peek_address = '0;
        lcg_state    = 32'h90e5;
        cycle_limit  = 100;

        build_alu_program();
        run_image("alu program");
        check_word(549, image[addr_t'(514)], "cp destination differs from source");
        check_word(550, image[addr_t'(550)], "unknown opcode wrote memory");
        check_word(551, image[addr_t'(513)] - image[addr_t'(512)],
                   "instruction after unknown opcode");

        build_branch_program();
        run_image("branch program");
        for (int k = 0; k < 7; k++) begin
            check_word(540 + k, marker_expect[k[3:0]], "branch marker");
        end

        for (int n = 0; n < 3; n++) begin
            build_random_program();
            run_image("random program");
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/e100_pkg.sv
common/e100_mem_if.sv
verilog/e100_memory.sv
e100_core/e100_fetch.sv
e100_core/e100_execute.sv
verilog/e100_top.sv
sim/e100_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the E100 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module e100_tb -f filelist.f -o e100_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/e100_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
